//--- all.f
+incdir+common
common/soc_pkg.sv
logic/reset_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/byte_fifo.sv
logic/soc_top.sv
testbench/soc_asserts.sv
testbench/tb_soc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_soc.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc;

    import soc_pkg::*;

    localparam int CLKS       = `SOC_CLKS_PER_BIT;
    localparam int FRAME      = 10 * CLKS;
    localparam int DEPTH      = 1 << `SOC_FIFO_DEPTH_LOG2;
    localparam int MAX_CYCLES = 180 * FRAME;  // about three times the length of the run

    logic       clk_pix_half = 1'b0;
    logic       arst_n;
    logic       btn_n;
    logic       rx;
    logic       cts_n;
    logic       tx;
    uart_byte_t display;
    logic       overflow;

    uart_byte_t exp_q[$];
    uart_byte_t got_q[$];
    string      test_name;
    integer     seed = 32'h358c;
    bit         cts_held;
    int         held_count;
    int         cycles = 0;

    soc_top dut_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n),
        .btn_n_i      (btn_n),
        .rx_i         (rx),
        .cts_n_i      (cts_n),
        .tx_o         (tx),
        .display_o    (display),
        .overflow_o   (overflow)
    );

    bind byte_fifo soc_asserts #(.TX_SIDE(1'b0)) fifo_asserts_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n_i),
        .rst_i        (rst_i),
        .pop_i        (pop_i),
        .empty_i      (empty_o),
        .tx_i         (1'b1),
        .state_i      (soc_pkg::UART_IDLE)
    );

    bind uart_tx soc_asserts #(.TX_SIDE(1'b1)) tx_asserts_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n_i),
        .rst_i        (rst_i),
        .pop_i        (pop_o),
        .empty_i      (empty_i),
        .tx_i         (tx_o),
        .state_i      (state)
    );

    always #10 clk_pix_half = ~clk_pix_half;

    always @(posedge clk_pix_half) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_pix_half);
            #1;
        end
    endtask

    // decides whether a byte sent on rx should come back on tx
    function automatic bit expected_echo(input bit bad_stop, input bit held, input int waiting);
        if (bad_stop) begin
            return 1'b0;  // framing error drops it
        end
        if (held && waiting >= DEPTH) begin
            return 1'b0;  // fifo already full
        end
        return 1'b1;
    endfunction

    task automatic send_frame(input uart_byte_t b, input bit bad_stop);
        rx = 1'b0;
        wait_cycles(CLKS);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            wait_cycles(CLKS);
        end
        rx = !bad_stop;
        wait_cycles(CLKS);
        rx = 1'b1;
        wait_cycles(4);
    endtask

    task automatic send_byte(input uart_byte_t b, input bit bad_stop);
        if (expected_echo(bad_stop, cts_held, held_count)) begin
            exp_q.push_back(b);
            if (cts_held) begin
                held_count++;
            end
        end
        send_frame(b, bad_stop);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            wait_cycles(1);
        end
    endtask

    // decode tx at mid-bit
    initial begin : tx_decode
        uart_byte_t b;
        forever begin
            @(negedge tx);
            repeat (CLKS / 2) @(negedge clk_pix_half);
            check_value("tx start bit", 32'd0, 32'(tx));
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk_pix_half);
                b[i] = tx;
            end
            repeat (CLKS) @(negedge clk_pix_half);
            check_value("tx stop bit", 32'd1, 32'(tx));
            got_q.push_back(b);
        end
    end

    initial begin : compare
        uart_byte_t b;
        forever begin
            @(negedge clk_pix_half);
            if (got_q.size() != 0) begin
                b = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("unexpected byte %02h on tx during test %s", b, test_name);
                    $display("Regression failed");
                    $fatal(1, "unexpected byte");
                end else begin
                    check_value(test_name, 32'(exp_q.pop_front()), 32'(b));
                end
            end
        end
    end

    initial begin : tests
        uart_byte_t b;
        arst_n     = 1'b0;
        btn_n      = 1'b1;
        rx         = 1'b1;
        cts_n      = 1'b0;
        cts_held   = 1'b0;
        held_count = 0;
        test_name  = "reset";
        wait_cycles(8);
        arst_n = 1'b1;

        check_value("reset display", 32'd0, 32'(display));
        check_value("reset overflow", 32'd0, 32'(overflow));
        repeat (`SOC_RESET_HOLD + 4) begin
            check_value("reset tx idle", 32'd1, 32'(tx));
            wait_cycles(1);
        end

        test_name = "single byte";
        b = 8'($random(seed));
        send_byte(b, 1'b0);
        wait_drained();
        check_value("single byte display", 32'(b), 32'(display));

        test_name = "burst of twelve";
        repeat (12) send_byte(8'($random(seed)), 1'b0);
        wait_drained();

        test_name = "bad stop bit";
        send_byte(8'($random(seed)), 1'b1);
        send_byte(8'($random(seed)), 1'b0);
        wait_drained();

        test_name = "cts hold overflow";
        cts_n    = 1'b1;
        cts_held = 1'b1;
        repeat (18) send_byte(8'($random(seed)), 1'b0);
        check_value("overflow after hold", 32'd1, 32'(overflow));
        cts_n      = 1'b0;
        cts_held   = 1'b0;
        held_count = 0;
        wait_drained();
        wait_cycles(2 * FRAME);  // a dropped byte sent anyway would show up here
        check_value("overflow after drain", 32'd1, 32'(overflow));

        test_name = "button reset";
        btn_n = 1'b0;
        wait_cycles(4);
        btn_n = 1'b1;
        wait_cycles(4);
        check_value("button overflow", 32'd0, 32'(overflow));
        check_value("button display", 32'd0, 32'(display));
        b = 8'($random(seed));
        send_byte(b, 1'b0);
        wait_drained();
        check_value("button display echo", 32'(b), 32'(display));

        wait_cycles(2 * FRAME);  // any stray frame shows up here
        check_value("stray frames", 32'd0, 32'(got_q.size()));
        $display("Regression passed");
        $finish;
    end

endmodule

//--- testbench/soc_asserts.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_asserts #(
    parameter bit TX_SIDE = 1'b0
) (
    input logic                 clk_pix_half,
    input logic                 arst_n_i,
    input logic                 rst_i,
    input logic                 pop_i,
    input logic                 empty_i,
    input logic                 tx_i,
    input soc_pkg::uart_state_e state_i
);

    import soc_pkg::*;

    localparam logic [7:0] CLKS = 8'(`SOC_CLKS_PER_BIT);

    if (TX_SIDE) begin : g_tx
        logic [7:0] start_cnt;  // cycles spent in the start bit

        always_ff @(posedge clk_pix_half or negedge arst_n_i) begin
            if (!arst_n_i) begin
                start_cnt <= '0;
            end else if (state_i == UART_START) begin
                start_cnt <= start_cnt + 1'b1;
            end else begin
                start_cnt <= '0;
            end
        end

        // line idles high through reset
        a_tx_idle_in_rst: assert property (@(posedge clk_pix_half) disable iff (!arst_n_i)
            rst_i && $past(rst_i) |-> tx_i)
            else $error("tx_o low while rst is held");

        a_start_len: assert property (@(posedge clk_pix_half) disable iff (!arst_n_i)
            $past(state_i == UART_START) && (state_i == UART_DATA) |-> start_cnt == CLKS)
            else $error("start bit length differs from one bit period");
    end else begin : g_fifo
        a_no_pop_empty: assert property (@(posedge clk_pix_half) disable iff (!arst_n_i)
            pop_i |-> !empty_i)
            else $error("pop while fifo empty");
    end

endmodule

//--- logic/soc_top.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
    input  logic                clk_pix_half,
    input  logic                arst_n_i,
    input  logic                btn_n_i,
    input  logic                rx_i,
    input  logic                cts_n_i,
    output logic                tx_o,
    output soc_pkg::uart_byte_t display_o,
    output logic                overflow_o
);

    import soc_pkg::*;

    logic       rst;
    logic       rx_valid;
    uart_byte_t rx_byte;
    uart_byte_t head_byte;
    logic       empty;
    logic       pop;

    reset_gen reset_gen_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n_i),
        .btn_n_i      (btn_n_i),
        .rst_o        (rst)
    );

    uart_rx #(
        .CLKS_PER_BIT (`SOC_CLKS_PER_BIT)
    ) uart_rx_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n_i),
        .rst_i        (rst),
        .rx_i         (rx_i),
        .rx_valid_o   (rx_valid),
        .rx_byte_o    (rx_byte),
        .frame_err_o  ()
    );

    byte_fifo #(
        .DEPTH_LOG2   (`SOC_FIFO_DEPTH_LOG2)
    ) byte_fifo_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n_i),
        .rst_i        (rst),
        .push_i       (rx_valid),
        .push_byte_i  (rx_byte),
        .pop_i        (pop),
        .head_byte_o  (head_byte),
        .empty_o      (empty),
        .full_o       (),
        .overflow_o   (overflow_o)
    );

    uart_tx #(
        .CLKS_PER_BIT (`SOC_CLKS_PER_BIT)
    ) uart_tx_i (
        .clk_pix_half (clk_pix_half),
        .arst_n_i     (arst_n_i),
        .rst_i        (rst),
        .empty_i      (empty),
        .head_byte_i  (head_byte),
        .cts_n_i      (cts_n_i),
        .pop_o        (pop),
        .tx_o         (tx_o),
        .sent_byte_o  (display_o)
    );

endmodule

//--- logic/byte_fifo.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module byte_fifo #(
    parameter int DEPTH_LOG2 = `SOC_FIFO_DEPTH_LOG2
) (
    input  logic                clk_pix_half,
    input  logic                arst_n_i,
    input  logic                rst_i,
    input  logic                push_i,
    input  soc_pkg::uart_byte_t push_byte_i,
    input  logic                pop_i,
    output soc_pkg::uart_byte_t head_byte_o,
    output logic                empty_o,
    output logic                full_o,
    output logic                overflow_o
);

    import soc_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    uart_byte_t            mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o     = (count == '0);
    assign full_o      = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign do_push     = push_i && !full_o;  // dropped when full
    assign do_pop      = pop_i && !empty_o;
    assign head_byte_o = mem[rd_ptr];        // show-ahead

    always_ff @(posedge clk_pix_half or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push_i && full_o) begin
                overflow_o <= 1'b1;  // sticky until rst
            end
        end
    end

    always_ff @(posedge clk_pix_half) begin
        if (do_push) begin
            mem[wr_ptr] <= push_byte_i;
        end
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `SOC_CLKS_PER_BIT
) (
    input  logic                clk_pix_half,
    input  logic                arst_n_i,
    input  logic                rst_i,
    input  logic                empty_i,
    input  soc_pkg::uart_byte_t head_byte_i,
    input  logic                cts_n_i,
    output logic                pop_o,
    output logic                tx_o,
    output soc_pkg::uart_byte_t sent_byte_o
);

    import soc_pkg::*;

    localparam int            CW   = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

    uart_state_e   state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    uart_byte_t    shift;
    logic          bit_end;

    assign bit_end = (cnt == LAST);
    assign pop_o   = (state == UART_IDLE) && !empty_i && !cts_n_i;  // cts only checked here

    always_ff @(posedge clk_pix_half or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= UART_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            tx_o        <= 1'b1;
            sent_byte_o <= '0;
        end else if (rst_i) begin
            state       <= UART_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            tx_o        <= 1'b1;
            sent_byte_o <= '0;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    cnt <= '0;
                    if (pop_o) begin
                        sent_byte_o <= head_byte_i;  // shown on the leds
                        tx_o        <= 1'b0;         // start bit
                        state       <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        tx_o    <= shift[0];
                        bit_idx <= '0;
                        state   <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;  // stop bit
                            state <= UART_STOP;
                        end else begin
                            tx_o <= shift[0];
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pix_half) begin
        if (pop_o) begin
            shift <= head_byte_i;
        end else if (bit_end && (state == UART_START || state == UART_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `SOC_CLKS_PER_BIT
) (
    input  logic                clk_pix_half,
    input  logic                arst_n_i,
    input  logic                rst_i,
    input  logic                rx_i,
    output logic                rx_valid_o,
    output soc_pkg::uart_byte_t rx_byte_o,
    output logic                frame_err_o
);

    import soc_pkg::*;

    localparam int            CW   = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] MID  = CW'(CLKS_PER_BIT / 2 - 1);

    uart_state_e   state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;
    logic          sample_bit;

    assign sample_bit = (state == UART_DATA) && (cnt == LAST);

    always_ff @(posedge clk_pix_half or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= UART_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            rx_prev     <= 1'b1;
            rx_valid_o  <= 1'b0;
            frame_err_o <= 1'b0;
        end else if (rst_i) begin
            state       <= UART_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            rx_prev     <= 1'b1;
            rx_valid_o  <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            rx_meta     <= rx_i;
            rx_sync     <= rx_meta;
            rx_prev     <= rx_sync;
            rx_valid_o  <= 1'b0;
            frame_err_o <= 1'b0;
            cnt         <= cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin  // falling edge
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (cnt == MID) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? UART_IDLE : UART_DATA;  // glitch goes back
                    end
                end
                UART_DATA: begin
                    if (cnt == LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (cnt == LAST) begin  // mid stop bit
                        rx_valid_o  <= rx_sync;
                        frame_err_o <= !rx_sync;
                        state       <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_pix_half) begin
        if (sample_bit) begin
            rx_byte_o <= {rx_sync, rx_byte_o[7:1]};
        end
    end

endmodule

//--- logic/reset_gen.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_gen (
    input  logic clk_pix_half,
    input  logic arst_n_i,
    input  logic btn_n_i,
    output logic rst_o
);

    localparam int HOLD = `SOC_RESET_HOLD;
    localparam int CW   = $clog2(HOLD + 1);

    logic [CW-1:0] hold_cnt;
    logic          hold;
    logic          btn_meta;
    logic          btn_sync;

    assign hold = (hold_cnt != CW'(HOLD));  // high until the counter saturates

    always_ff @(posedge clk_pix_half or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_cnt <= '0;
            btn_meta <= 1'b1;
            btn_sync <= 1'b1;
        end else begin
            btn_meta <= btn_n_i;
            btn_sync <= btn_meta;
            if (hold) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    assign rst_o = hold || !btn_sync;  // button is active low

endmodule

//--- common/soc_pkg.sv
package soc_pkg;

    // one data byte of a uart frame
    typedef logic [7:0] uart_byte_t;

    // frame phase shared by receiver and transmitter
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_e;

endpackage

//--- common/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// clk_pix_half runs at half the 480p pixel clock
`define SOC_FREQ_HZ 12562500

`define SOC_BAUDS 115200

// 109 clocks per uart bit
`define SOC_CLKS_PER_BIT (`SOC_FREQ_HZ / `SOC_BAUDS)

// 16 entries
`define SOC_FIFO_DEPTH_LOG2 4

// power-on reset length in cycles
`define SOC_RESET_HOLD 31

`endif
